// File: common/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath widths
`define EXEC_DATA_W 32
`define EXEC_REG_W 5

// ==============================
// primary opcodes, instr[31:26]
// ==============================
`define EXEC_OP_SPECIAL 6'h00
`define EXEC_OP_REGIMM 6'h01
`define EXEC_OP_BEQ 6'h04
`define EXEC_OP_BNE 6'h05
`define EXEC_OP_BLEZ 6'h06
`define EXEC_OP_BGTZ 6'h07
`define EXEC_OP_ADDI 6'h08
`define EXEC_OP_ADDIU 6'h09
`define EXEC_OP_SLTI 6'h0a
`define EXEC_OP_SLTIU 6'h0b
`define EXEC_OP_ANDI 6'h0c
`define EXEC_OP_ORI 6'h0d
`define EXEC_OP_XORI 6'h0e
`define EXEC_OP_LUI 6'h0f

// ==============================
// funct codes under SPECIAL
// ==============================
`define EXEC_FN_SLL 6'h00
`define EXEC_FN_SRL 6'h02
`define EXEC_FN_SRA 6'h03
`define EXEC_FN_ADD 6'h20
`define EXEC_FN_ADDU 6'h21
`define EXEC_FN_SUB 6'h22
`define EXEC_FN_SUBU 6'h23
`define EXEC_FN_AND 6'h24
`define EXEC_FN_OR 6'h25
`define EXEC_FN_XOR 6'h26
`define EXEC_FN_NOR 6'h27
`define EXEC_FN_SLT 6'h2a
`define EXEC_FN_SLTU 6'h2b

// REGIMM selectors, carried in rt
`define EXEC_RT_BLTZ 5'h00
`define EXEC_RT_BGEZ 5'h01

// decode + execute + merge, strobe in to result out
`define EXEC_LATENCY 3

`endif

// File: common/execPkg.sv
`default_nettype none

`include "exec_config.svh"

package execPkg;

	// register file address
	typedef logic [`EXEC_REG_W-1:0] regAddr_t;

	// register-register layout
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} rType_t;

	// immediate layout, also used by branches
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iType_t;

	// one fetched word, two readings
	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instrWord_u;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOp_e;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brGtz,
		brLez,
		brGez,
		brLtz
	} brCond_e;

endpackage

`default_nettype wire

// File: source/instrDecode.sv
`default_nettype none

`include "exec_config.svh"

module instrDecode (
	input  logic clk,
	input  logic rstN,
	input  logic instValid,
	input  execPkg::instrWord_u instr,
	input  logic [`EXEC_DATA_W-1:0] pc,
	input  logic [`EXEC_DATA_W-1:0] rsValue,
	input  logic [`EXEC_DATA_W-1:0] rtValue,
	output logic decValid,
	output execPkg::aluOp_e aluOp,
	output logic [`EXEC_DATA_W-1:0] opA,
	output logic [`EXEC_DATA_W-1:0] opB,
	output logic overflowCheck,
	output execPkg::regAddr_t destReg,
	output logic reserved,
	output execPkg::brCond_e brCond,
	output logic [`EXEC_DATA_W-1:0] brRs,
	output logic [`EXEC_DATA_W-1:0] brRt,
	output logic [`EXEC_DATA_W-1:0] brBase,
	output logic [`EXEC_DATA_W-1:0] brOffset
);
	import execPkg::*;

	logic [`EXEC_DATA_W-1:0] signImm;
	logic [`EXEC_DATA_W-1:0] zeroImm;
	aluOp_e aluOpNext;
	logic [`EXEC_DATA_W-1:0] opANext;
	logic [`EXEC_DATA_W-1:0] opBNext;
	logic ovfNext;
	regAddr_t destNext;
	logic reservedNext;
	brCond_e brCondNext;

	// immediate extensions
	assign signImm = {{(`EXEC_DATA_W-16){instr.iType.imm[15]}}, instr.iType.imm};
	assign zeroImm = {{(`EXEC_DATA_W-16){1'b0}}, instr.iType.imm};

	// ==============================
	// field decode
	// ==============================
	always_comb begin
		// defaults: rs op rt, no write, no branch
		aluOpNext = aluAdd;
		opANext = rsValue;
		opBNext = rtValue;
		ovfNext = 1'b0;
		destNext = '0;
		reservedNext = 1'b0;
		brCondNext = brNone;
		if (instr.rType.opcode == `EXEC_OP_SPECIAL) begin
			// R-type view, result goes to rd
			destNext = instr.rType.rd;
			case (instr.rType.funct)
				`EXEC_FN_ADD: begin
					aluOpNext = aluAdd;
					ovfNext = 1'b1;
				end
				`EXEC_FN_ADDU: aluOpNext = aluAdd;
				`EXEC_FN_SUB: begin
					aluOpNext = aluSub;
					ovfNext = 1'b1;
				end
				`EXEC_FN_SUBU: aluOpNext = aluSub;
				`EXEC_FN_AND: aluOpNext = aluAnd;
				`EXEC_FN_OR: aluOpNext = aluOr;
				`EXEC_FN_XOR: aluOpNext = aluXor;
				`EXEC_FN_NOR: aluOpNext = aluNor;
				`EXEC_FN_SLT: aluOpNext = aluSlt;
				`EXEC_FN_SLTU: aluOpNext = aluSltu;
				`EXEC_FN_SLL: aluOpNext = aluSll;
				`EXEC_FN_SRL: aluOpNext = aluSrl;
				`EXEC_FN_SRA: aluOpNext = aluSra;
				default: reservedNext = 1'b1;
			endcase
			// shift amount from sa, value from rt
			if (aluOpNext inside {aluSll, aluSrl, aluSra})
				opANext = `EXEC_DATA_W'(instr.rType.sa);
		end else begin
			// I-type view, result goes to rt
			destNext = instr.iType.rt;
			opBNext = signImm;
			case (instr.iType.opcode)
				`EXEC_OP_ADDI: begin
					aluOpNext = aluAdd;
					ovfNext = 1'b1;
				end
				`EXEC_OP_ADDIU: aluOpNext = aluAdd;
				`EXEC_OP_SLTI: aluOpNext = aluSlt;
				// sign-extended imm, compared unsigned
				`EXEC_OP_SLTIU: aluOpNext = aluSltu;
				`EXEC_OP_ANDI: begin
					aluOpNext = aluAnd;
					opBNext = zeroImm;
				end
				`EXEC_OP_ORI: begin
					aluOpNext = aluOr;
					opBNext = zeroImm;
				end
				`EXEC_OP_XORI: begin
					aluOpNext = aluXor;
					opBNext = zeroImm;
				end
				`EXEC_OP_LUI: begin
					aluOpNext = aluLui;
					opBNext = {instr.iType.imm, 16'h0000};
				end
				`EXEC_OP_BEQ: brCondNext = brEq;
				`EXEC_OP_BNE: brCondNext = brNe;
				`EXEC_OP_BLEZ: brCondNext = brLez;
				`EXEC_OP_BGTZ: brCondNext = brGtz;
				`EXEC_OP_REGIMM: begin
					// rt selects the condition here
					case (instr.iType.rt)
						`EXEC_RT_BLTZ: brCondNext = brLtz;
						`EXEC_RT_BGEZ: brCondNext = brGez;
						default: reservedNext = 1'b1;
					endcase
				end
				default: reservedNext = 1'b1;
			endcase
		end
		// branches and unknown codes never write
		if (reservedNext || brCondNext != brNone)
			destNext = '0;
	end

	// ==============================
	// stage register
	// ==============================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			decValid <= 1'b0;
		else
			decValid <= instValid;
	end

	// payload only moves on a strobe
	always_ff @(posedge clk) begin
		if (instValid) begin
			aluOp <= aluOpNext;
			opA <= opANext;
			opB <= opBNext;
			overflowCheck <= ovfNext;
			destReg <= destNext;
			reserved <= reservedNext;
			brCond <= brCondNext;
			brRs <= rsValue;
			brRt <= rtValue;
			brBase <= pc + `EXEC_DATA_W'(4);
			brOffset <= {signImm[`EXEC_DATA_W-3:0], 2'b00};
		end
	end

	// upstream must present a clean word with each strobe
	instrKnown: assert property (@(posedge clk) disable iff (!rstN)
		instValid |-> !$isunknown(instr))
		else $error("instrDecode: unknown bits in instr on strobe");

endmodule

`default_nettype wire

// File: alu/aluCore.sv
`default_nettype none

`include "exec_config.svh"

module aluCore (
	input  logic clk,
	input  logic rstN,
	input  logic decValid,
	input  execPkg::aluOp_e aluOp,
	input  logic [`EXEC_DATA_W-1:0] opA,
	input  logic [`EXEC_DATA_W-1:0] opB,
	input  logic overflowCheck,
	input  execPkg::regAddr_t destIn,
	input  logic reservedIn,
	output logic aluValid,
	output logic [`EXEC_DATA_W-1:0] aluResult,
	output logic aluOverflow,
	output execPkg::regAddr_t aluDest,
	output logic aluReserved
);
	import execPkg::*;

	localparam int MSB = `EXEC_DATA_W - 1;

	logic [`EXEC_DATA_W-1:0] sum;
	logic [`EXEC_DATA_W-1:0] diff;
	logic [`EXEC_DATA_W-1:0] resultNext;
	logic [4:0] shamt;
	logic addOvf;
	logic subOvf;
	logic ovfNext;

	// shared adder and subtractor
	assign sum = opA + opB;
	assign diff = opA - opB;
	assign shamt = opA[4:0];

	// ==============================
	// signed overflow
	// ==============================
	// add: same input signs, result sign flips
	assign addOvf = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
	// sub: signs differ, result takes sign of opB
	assign subOvf = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);
	// only trapping forms report it
	assign ovfNext = overflowCheck &&
		((aluOp == aluAdd && addOvf) || (aluOp == aluSub && subOvf));

	// operation select
	always_comb begin
		case (aluOp)
			aluAdd: resultNext = sum;
			aluSub: resultNext = diff;
			aluAnd: resultNext = opA & opB;
			aluOr: resultNext = opA | opB;
			aluXor: resultNext = opA ^ opB;
			aluNor: resultNext = ~(opA | opB);
			aluSlt: resultNext = `EXEC_DATA_W'($signed(opA) < $signed(opB));
			aluSltu: resultNext = `EXEC_DATA_W'(opA < opB);
			aluSll: resultNext = opB << shamt;
			aluSrl: resultNext = opB >> shamt;
			aluSra: resultNext = $signed(opB) >>> shamt;
			// imm already placed in the upper half
			aluLui: resultNext = opB;
			default: resultNext = sum;
		endcase
	end

	// ==============================
	// output register
	// ==============================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			aluValid <= 1'b0;
		else
			aluValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			aluResult <= resultNext;
			aluOverflow <= ovfNext;
			aluDest <= destIn;
			aluReserved <= reservedIn;
		end
	end

endmodule

`default_nettype wire

// File: source/branchCompare.sv
`default_nettype none

`include "exec_config.svh"

module branchCompare (
	input  logic clk,
	input  logic rstN,
	input  logic decValid,
	input  execPkg::brCond_e brCond,
	input  logic [`EXEC_DATA_W-1:0] brRs,
	input  logic [`EXEC_DATA_W-1:0] brRt,
	input  logic [`EXEC_DATA_W-1:0] brBase,
	input  logic [`EXEC_DATA_W-1:0] brOffset,
	output logic brValid,
	output logic brTaken,
	output logic [`EXEC_DATA_W-1:0] brTarget
);
	import execPkg::*;

	logic rsZero;
	logic rsNeg;
	logic takenNext;

	// rs tested as a signed value
	assign rsZero = (brRs == '0);
	assign rsNeg = brRs[`EXEC_DATA_W-1];

	always_comb begin
		case (brCond)
			brEq: takenNext = (brRs == brRt);
			brNe: takenNext = (brRs != brRt);
			brGtz: takenNext = !rsNeg && !rsZero;
			brLez: takenNext = rsNeg || rsZero;
			brGez: takenNext = !rsNeg;
			brLtz: takenNext = rsNeg;
			// brNone, not a branch
			default: takenNext = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			brValid <= 1'b0;
		else
			brValid <= decValid;
	end

	// target = pc + 4 + (imm << 2)
	always_ff @(posedge clk) begin
		if (decValid) begin
			brTaken <= takenNext;
			brTarget <= brBase + brOffset;
		end
	end

endmodule

`default_nettype wire

// File: source/resultMerge.sv
`default_nettype none

`include "exec_config.svh"

module resultMerge (
	input  logic clk,
	input  logic rstN,
	input  logic aluValid,
	input  logic [`EXEC_DATA_W-1:0] aluResult,
	input  logic aluOverflow,
	input  execPkg::regAddr_t aluDest,
	input  logic aluReserved,
	input  logic brValid,
	input  logic brTaken,
	input  logic [`EXEC_DATA_W-1:0] brTarget,
	output logic resultValid,
	output logic writeEn,
	output execPkg::regAddr_t writeReg,
	output logic [`EXEC_DATA_W-1:0] writeData,
	output logic branchTaken,
	output logic [`EXEC_DATA_W-1:0] branchTarget,
	output logic excOverflow,
	output logic excReserved
);
	import execPkg::*;

	logic validIn;
	logic writeEnNext;
	logic takenNext;
	regAddr_t writeRegNext;
	logic [`EXEC_DATA_W-1:0] writeDataNext;

	// both halves arrive in the same cycle
	assign validIn = aluValid && brValid;

	// r0 is never written
	// either exception cancels the write
	assign writeEnNext = validIn && (aluDest != '0) && !aluOverflow && !aluReserved;
	assign writeRegNext = writeEnNext ? aluDest : '0;
	assign writeDataNext = writeEnNext ? aluResult : '0;
	assign takenNext = validIn && brTaken;

	// ==============================
	// output register
	// ==============================
	// idle cycles drive everything to zero
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			writeEn <= 1'b0;
			writeReg <= '0;
			writeData <= '0;
			branchTaken <= 1'b0;
			branchTarget <= '0;
			excOverflow <= 1'b0;
			excReserved <= 1'b0;
		end else begin
			resultValid <= validIn;
			writeEn <= writeEnNext;
			writeReg <= writeRegNext;
			writeData <= writeDataNext;
			branchTaken <= takenNext;
			branchTarget <= takenNext ? brTarget : '0;
			excOverflow <= validIn && aluOverflow;
			excReserved <= validIn && aluReserved;
		end
	end

	// decode zeroes the destination of every branch
	noWriteOnBranch: assert property (@(posedge clk) disable iff (!rstN)
		!(writeEn && branchTaken))
		else $error("resultMerge: write and branch in the same result");

	// ALU and comparator are the same depth
	parallelValid: assert property (@(posedge clk) disable iff (!rstN)
		aluValid == brValid)
		else $error("resultMerge: aluValid and brValid out of step");

endmodule

`default_nettype wire

// File: source/mipsExec.sv
`default_nettype none

`include "exec_config.svh"

module mipsExec (
	input  logic clk,
	input  logic rstN,
	input  logic instValid,
	input  execPkg::instrWord_u instr,
	input  logic [`EXEC_DATA_W-1:0] pc,
	input  logic [`EXEC_DATA_W-1:0] rsValue,
	input  logic [`EXEC_DATA_W-1:0] rtValue,
	output logic resultValid,
	output logic writeEn,
	output execPkg::regAddr_t writeReg,
	output logic [`EXEC_DATA_W-1:0] writeData,
	output logic branchTaken,
	output logic [`EXEC_DATA_W-1:0] branchTarget,
	output logic excOverflow,
	output logic excReserved
);
	import execPkg::*;

	// ==============================
	// decode to execute
	// ==============================
	logic decValid;
	aluOp_e aluOp;
	logic [`EXEC_DATA_W-1:0] opA;
	logic [`EXEC_DATA_W-1:0] opB;
	logic overflowCheck;
	regAddr_t destReg;
	logic reserved;
	brCond_e brCond;
	logic [`EXEC_DATA_W-1:0] brRs;
	logic [`EXEC_DATA_W-1:0] brRt;
	logic [`EXEC_DATA_W-1:0] brBase;
	logic [`EXEC_DATA_W-1:0] brOffset;

	// ==============================
	// execute to merge
	// ==============================
	logic aluValid;
	logic [`EXEC_DATA_W-1:0] aluResult;
	logic aluOverflow;
	regAddr_t aluDest;
	logic aluReserved;
	logic brValid;
	logic brTaken;
	logic [`EXEC_DATA_W-1:0] brTarget;

	// stage 1
	instrDecode uDecode (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instr(instr),
		.pc(pc),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.decValid(decValid),
		.aluOp(aluOp),
		.opA(opA),
		.opB(opB),
		.overflowCheck(overflowCheck),
		.destReg(destReg),
		.reserved(reserved),
		.brCond(brCond),
		.brRs(brRs),
		.brRt(brRt),
		.brBase(brBase),
		.brOffset(brOffset)
	);

	// stage 2, two units side by side
	aluCore uAlu (
		.clk(clk),
		.rstN(rstN),
		.decValid(decValid),
		.aluOp(aluOp),
		.opA(opA),
		.opB(opB),
		.overflowCheck(overflowCheck),
		.destIn(destReg),
		.reservedIn(reserved),
		.aluValid(aluValid),
		.aluResult(aluResult),
		.aluOverflow(aluOverflow),
		.aluDest(aluDest),
		.aluReserved(aluReserved)
	);

	branchCompare uBranch (
		.clk(clk),
		.rstN(rstN),
		.decValid(decValid),
		.brCond(brCond),
		.brRs(brRs),
		.brRt(brRt),
		.brBase(brBase),
		.brOffset(brOffset),
		.brValid(brValid),
		.brTaken(brTaken),
		.brTarget(brTarget)
	);

	// stage 3
	resultMerge uMerge (
		.clk(clk),
		.rstN(rstN),
		.aluValid(aluValid),
		.aluResult(aluResult),
		.aluOverflow(aluOverflow),
		.aluDest(aluDest),
		.aluReserved(aluReserved),
		.brValid(brValid),
		.brTaken(brTaken),
		.brTarget(brTarget),
		.resultValid(resultValid),
		.writeEn(writeEn),
		.writeReg(writeReg),
		.writeData(writeData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.excOverflow(excOverflow),
		.excReserved(excReserved)
	);

endmodule

`default_nettype wire

// File: dv/mipsExecTb.sv
`default_nettype none

`include "exec_config.svh"

module mipsExecTb;
	import execPkg::*;

	localparam int driveDelay = 10;
	localparam int aluStrobes = 21;
	localparam int ovfStrobes = 8;
	localparam int branchStrobes = 12;
	localparam int reservedStrobes = 5;
	localparam int randomStrobes = 300;
	localparam int totalStrobes = aluStrobes + ovfStrobes + branchStrobes +
		reservedStrobes + randomStrobes;
	// twice the strobes plus room for reset and drains
	localparam int cycleLimit = 2 * totalStrobes + 50;
	localparam logic [31:0] basePc = 32'h0040_0000;

	// one strobe as sent
	typedef struct packed {
		logic [31:0] word;
		logic [`EXEC_DATA_W-1:0] pc;
		logic [`EXEC_DATA_W-1:0] rs;
		logic [`EXEC_DATA_W-1:0] rt;
		logic [31:0] cycle;
	} stimRec_t;

	// expected DUT outputs for one result
	typedef struct packed {
		logic writeEn;
		logic [`EXEC_REG_W-1:0] writeReg;
		logic [`EXEC_DATA_W-1:0] writeData;
		logic branchTaken;
		logic [`EXEC_DATA_W-1:0] branchTarget;
		logic excOverflow;
		logic excReserved;
	} expect_t;

	logic clk;
	logic rstN;
	logic instValid;
	instrWord_u instr;
	logic [`EXEC_DATA_W-1:0] pc;
	logic [`EXEC_DATA_W-1:0] rsValue;
	logic [`EXEC_DATA_W-1:0] rtValue;
	logic resultValid;
	logic writeEn;
	regAddr_t writeReg;
	logic [`EXEC_DATA_W-1:0] writeData;
	logic branchTaken;
	logic [`EXEC_DATA_W-1:0] branchTarget;
	logic excOverflow;
	logic excReserved;

	stimRec_t pending[$];
	int cycleCount;
	int errorCount;
	int checkCount;
	int failedTests;
	int errMark;

	mipsExec DUT (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instr(instr),
		.pc(pc),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.resultValid(resultValid),
		.writeEn(writeEn),
		.writeReg(writeReg),
		.writeData(writeData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.excOverflow(excOverflow),
		.excReserved(excReserved)
	);

	always #50 clk = ~clk;

	// cycle count doubles as the run bound
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: run not finished after %0d cycles, %0d results still pending",
				cycleLimit, pending.size());
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ==============================
	// reference model
	// ==============================
	function automatic expect_t expectOut(input logic [31:0] word,
		input logic [31:0] pcIn, input logic [31:0] rs, input logic [31:0] rt);
		expect_t e;
		logic [5:0] opcode;
		logic [5:0] funct;
		logic [4:0] rtField;
		logic [4:0] sa;
		logic [31:0] immS;
		logic [31:0] immZ;
		logic [31:0] value;
		logic [31:0] target;
		logic [32:0] wide;
		logic [4:0] dest;
		logic ovf;
		logic bad;
		logic isBranch;
		logic taken;
		opcode = word[31:26];
		rtField = word[20:16];
		sa = word[10:6];
		funct = word[5:0];
		immS = {{16{word[15]}}, word[15:0]};
		immZ = {16'h0000, word[15:0]};
		target = pcIn + 32'd4 + (immS << 2);
		value = '0;
		dest = '0;
		ovf = 1'b0;
		bad = 1'b0;
		isBranch = 1'b0;
		taken = 1'b0;
		if (opcode == `EXEC_OP_SPECIAL) begin
			// result lands in rd
			dest = word[15:11];
			case (funct)
				`EXEC_FN_ADD: begin
					wide = {rs[31], rs} + {rt[31], rt};
					value = wide[31:0];
					ovf = wide[32] != wide[31];
				end
				`EXEC_FN_ADDU: value = rs + rt;
				`EXEC_FN_SUB: begin
					wide = {rs[31], rs} - {rt[31], rt};
					value = wide[31:0];
					ovf = wide[32] != wide[31];
				end
				`EXEC_FN_SUBU: value = rs - rt;
				`EXEC_FN_AND: value = rs & rt;
				`EXEC_FN_OR: value = rs | rt;
				`EXEC_FN_XOR: value = rs ^ rt;
				`EXEC_FN_NOR: value = ~(rs | rt);
				`EXEC_FN_SLT: value = {31'b0, $signed(rs) < $signed(rt)};
				`EXEC_FN_SLTU: value = {31'b0, rs < rt};
				`EXEC_FN_SLL: value = rt << sa;
				`EXEC_FN_SRL: value = rt >> sa;
				`EXEC_FN_SRA: value = $signed(rt) >>> sa;
				default: bad = 1'b1;
			endcase
		end else begin
			// result lands in rt
			dest = rtField;
			case (opcode)
				`EXEC_OP_ADDI: begin
					wide = {rs[31], rs} + {immS[31], immS};
					value = wide[31:0];
					ovf = wide[32] != wide[31];
				end
				`EXEC_OP_ADDIU: value = rs + immS;
				`EXEC_OP_SLTI: value = {31'b0, $signed(rs) < $signed(immS)};
				`EXEC_OP_SLTIU: value = {31'b0, rs < immS};
				`EXEC_OP_ANDI: value = rs & immZ;
				`EXEC_OP_ORI: value = rs | immZ;
				`EXEC_OP_XORI: value = rs ^ immZ;
				`EXEC_OP_LUI: value = {word[15:0], 16'h0000};
				`EXEC_OP_BEQ: begin
					isBranch = 1'b1;
					taken = (rs == rt);
				end
				`EXEC_OP_BNE: begin
					isBranch = 1'b1;
					taken = (rs != rt);
				end
				`EXEC_OP_BLEZ: begin
					isBranch = 1'b1;
					taken = ($signed(rs) <= 32'sd0);
				end
				`EXEC_OP_BGTZ: begin
					isBranch = 1'b1;
					taken = ($signed(rs) > 32'sd0);
				end
				`EXEC_OP_REGIMM: begin
					isBranch = 1'b1;
					if (rtField == `EXEC_RT_BLTZ)
						taken = ($signed(rs) < 32'sd0);
					else if (rtField == `EXEC_RT_BGEZ)
						taken = ($signed(rs) >= 32'sd0);
					else
						bad = 1'b1;
				end
				default: bad = 1'b1;
			endcase
		end
		// no destination for branches or unknown codes
		if (bad || isBranch)
			dest = '0;
		e.writeEn = (dest != 5'd0) && !ovf && !bad;
		e.writeReg = e.writeEn ? dest : 5'd0;
		e.writeData = e.writeEn ? value : 32'd0;
		e.branchTaken = taken && !bad;
		e.branchTarget = e.branchTaken ? target : 32'd0;
		e.excOverflow = ovf;
		e.excReserved = bad;
		return e;
	endfunction

	task automatic checkVal(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// ==============================
	// compare process
	// ==============================
	// outputs sampled at the falling edge mid-cycle
	always @(negedge clk) begin : compare
		stimRec_t rec;
		expect_t want;
		if (rstN) begin
			if (resultValid) begin
				if (pending.size() == 0) begin
					errorCount++;
					$display("resultValid came at %0t with no instruction in flight", $time);
				end else begin
					rec = pending.pop_front();
					if (cycleCount != rec.cycle + `EXEC_LATENCY) begin
						errorCount++;
						$display("result for %h at %0t came %0d cycles after its strobe",
							rec.word, $time, cycleCount - rec.cycle);
					end
					want = expectOut(rec.word, rec.pc, rec.rs, rec.rt);
					checkVal("writeEn", writeEn, want.writeEn);
					checkVal("writeReg", writeReg, want.writeReg);
					checkVal("writeData", writeData, want.writeData);
					checkVal("branchTaken", branchTaken, want.branchTaken);
					checkVal("branchTarget", branchTarget, want.branchTarget);
					checkVal("excOverflow", excOverflow, want.excOverflow);
					checkVal("excReserved", excReserved, want.excReserved);
				end
			end else begin
				// everything held at zero when idle
				checkVal("idle writeData", writeData, 32'd0);
				checkVal("idle branchTarget", branchTarget, 32'd0);
				checkVal("idle flags", {writeReg, writeEn, branchTaken, excOverflow,
					excReserved}, 32'd0);
				if (pending.size() != 0 && cycleCount >= pending[0].cycle + `EXEC_LATENCY) begin
					errorCount++;
					$display("resultValid missing at %0t for instruction %h",
						$time, pending[0].word);
					rec = pending.pop_front();
				end
			end
		end
	end

	// ==============================
	// stimulus helpers
	// ==============================
	// rs field is 1 and rt field is 2
	function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] sa);
		return {`EXEC_OP_SPECIAL, 5'd1, 5'd2, rd, sa, funct};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] opcode, input logic [4:0] rt,
		input logic [15:0] imm);
		return {opcode, 5'd1, rt, imm};
	endfunction

	function automatic logic [5:0] legalFunct(input int idx);
		case (idx)
			0: return `EXEC_FN_ADD;
			1: return `EXEC_FN_ADDU;
			2: return `EXEC_FN_SUB;
			3: return `EXEC_FN_SUBU;
			4: return `EXEC_FN_AND;
			5: return `EXEC_FN_OR;
			6: return `EXEC_FN_XOR;
			7: return `EXEC_FN_NOR;
			8: return `EXEC_FN_SLT;
			9: return `EXEC_FN_SLTU;
			10: return `EXEC_FN_SLL;
			11: return `EXEC_FN_SRL;
			default: return `EXEC_FN_SRA;
		endcase
	endfunction

	function automatic logic [5:0] legalOpcode(input int idx);
		case (idx)
			0: return `EXEC_OP_ADDI;
			1: return `EXEC_OP_ADDIU;
			2: return `EXEC_OP_SLTI;
			3: return `EXEC_OP_SLTIU;
			4: return `EXEC_OP_ANDI;
			5: return `EXEC_OP_ORI;
			6: return `EXEC_OP_XORI;
			7: return `EXEC_OP_LUI;
			8: return `EXEC_OP_BEQ;
			9: return `EXEC_OP_BNE;
			10: return `EXEC_OP_BLEZ;
			default: return `EXEC_OP_BGTZ;
		endcase
	endfunction

	// mostly legal words with some unknown codes
	function automatic logic [31:0] randomInstr();
		logic [31:0] word;
		int kind;
		word = $urandom;
		kind = $urandom_range(0, 9);
		if (kind < 4)
			word = {`EXEC_OP_SPECIAL, word[25:6], legalFunct($urandom_range(0, 12))};
		else if (kind < 7)
			word[31:26] = legalOpcode($urandom_range(0, 11));
		else if (kind == 7)
			// rt 0..3 where two are unused
			word = {`EXEC_OP_REGIMM, word[25:21], 3'b000, word[17:0]};
		else if (kind == 8)
			word[31:26] = `EXEC_OP_SPECIAL;
		return word;
	endfunction

	// edge values often to hit overflow and branch boundaries
	function automatic logic [31:0] pickOperand();
		case ($urandom_range(0, 7))
			0: return 32'h0000_0000;
			1: return 32'h7fff_ffff;
			2: return 32'h8000_0000;
			3: return 32'hffff_ffff;
			4: return 32'h0000_0001;
			default: return $urandom;
		endcase
	endfunction

	task automatic sendInstr(input logic [31:0] word, input logic [31:0] pcIn,
		input logic [31:0] rs, input logic [31:0] rt);
		stimRec_t rec;
		@(posedge clk);
		#driveDelay;
		instValid = 1'b1;
		instr = word;
		pc = pcIn;
		rsValue = rs;
		rtValue = rt;
		rec.word = word;
		rec.pc = pcIn;
		rec.rs = rs;
		rec.rt = rt;
		rec.cycle = cycleCount;
		pending.push_back(rec);
	endtask

	task automatic goIdle();
		@(posedge clk);
		#driveDelay;
		instValid = 1'b0;
		instr = '0;
		pc = '0;
		rsValue = '0;
		rtValue = '0;
	endtask

	task automatic finishTest(input string name, input int strobes, input int errBefore);
		int errs;
		goIdle();
		while (pending.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		errs = errorCount - errBefore;
		if (errs != 0)
			failedTests++;
		$display("test %s done: %0d instructions, %0d errors", name, strobes, errs);
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic driveAluOps();
		sendInstr(encodeR(`EXEC_FN_ADD, 5'd3, 5'd0), basePc, 32'd5, 32'd7);
		sendInstr(encodeR(`EXEC_FN_ADDU, 5'd4, 5'd0), basePc, 32'hffff_ffff, 32'd2);
		sendInstr(encodeR(`EXEC_FN_SUB, 5'd5, 5'd0), basePc, 32'd10, 32'd3);
		sendInstr(encodeR(`EXEC_FN_SUBU, 5'd6, 5'd0), basePc, 32'd3, 32'd10);
		sendInstr(encodeR(`EXEC_FN_AND, 5'd7, 5'd0), basePc, 32'hf0f0_f0f0, 32'hff00_ff00);
		sendInstr(encodeR(`EXEC_FN_OR, 5'd8, 5'd0), basePc, 32'hf0f0_f0f0, 32'hff00_ff00);
		sendInstr(encodeR(`EXEC_FN_XOR, 5'd9, 5'd0), basePc, 32'hf0f0_f0f0, 32'hff00_ff00);
		sendInstr(encodeR(`EXEC_FN_NOR, 5'd10, 5'd0), basePc, 32'hf0f0_f0f0, 32'h0000_ff00);
		// -1 < 1 signed but not unsigned
		sendInstr(encodeR(`EXEC_FN_SLT, 5'd11, 5'd0), basePc, 32'hffff_ffff, 32'd1);
		sendInstr(encodeR(`EXEC_FN_SLTU, 5'd12, 5'd0), basePc, 32'hffff_ffff, 32'd1);
		// shifts take sa and ignore the rs value
		sendInstr(encodeR(`EXEC_FN_SLL, 5'd13, 5'd4), basePc, 32'hdead_beef, 32'h8000_0001);
		sendInstr(encodeR(`EXEC_FN_SRL, 5'd14, 5'd8), basePc, 32'hdead_beef, 32'h8000_0000);
		sendInstr(encodeR(`EXEC_FN_SRA, 5'd15, 5'd8), basePc, 32'hdead_beef, 32'h8000_0000);
		sendInstr(encodeI(`EXEC_OP_ADDI, 5'd16, 16'hffff), basePc, 32'd100, 32'd0);
		sendInstr(encodeI(`EXEC_OP_ADDIU, 5'd17, 16'h8000), basePc, 32'd5, 32'd0);
		sendInstr(encodeI(`EXEC_OP_SLTI, 5'd18, 16'h0002), basePc, 32'hffff_fffb, 32'd0);
		// imm sign-extended then compared unsigned
		sendInstr(encodeI(`EXEC_OP_SLTIU, 5'd19, 16'hffff), basePc, 32'h0001_0000, 32'd0);
		// logic immediates zero-extend
		sendInstr(encodeI(`EXEC_OP_ANDI, 5'd20, 16'hff00), basePc, 32'hffff_ffff, 32'd0);
		sendInstr(encodeI(`EXEC_OP_ORI, 5'd21, 16'h8001), basePc, 32'h1234_0000, 32'd0);
		sendInstr(encodeI(`EXEC_OP_XORI, 5'd22, 16'h80ff), basePc, 32'hffff_ffff, 32'd0);
		sendInstr(encodeI(`EXEC_OP_LUI, 5'd23, 16'h1234), basePc, 32'hffff_ffff, 32'd0);
	endtask

	// trapping forms flag while unsigned forms wrap
	task automatic checkOverflowLimits();
		sendInstr(encodeR(`EXEC_FN_ADD, 5'd3, 5'd0), basePc, 32'h7fff_ffff, 32'd1);
		sendInstr(encodeR(`EXEC_FN_ADDU, 5'd3, 5'd0), basePc, 32'h7fff_ffff, 32'd1);
		sendInstr(encodeR(`EXEC_FN_SUB, 5'd3, 5'd0), basePc, 32'h8000_0000, 32'd1);
		sendInstr(encodeR(`EXEC_FN_SUBU, 5'd3, 5'd0), basePc, 32'h8000_0000, 32'd1);
		sendInstr(encodeI(`EXEC_OP_ADDI, 5'd4, 16'h0001), basePc, 32'h7fff_ffff, 32'd0);
		sendInstr(encodeI(`EXEC_OP_ADDIU, 5'd4, 16'h0001), basePc, 32'h7fff_ffff, 32'd0);
		sendInstr(encodeI(`EXEC_OP_ADDI, 5'd4, 16'hffff), basePc, 32'h8000_0000, 32'd0);
		sendInstr(encodeR(`EXEC_FN_ADD, 5'd3, 5'd0), basePc, 32'h8000_0000, 32'h8000_0000);
	endtask

	// each condition on both sides of its boundary
	task automatic walkBranches();
		logic [31:0] bpc;
		bpc = basePc + 32'h100;
		sendInstr(encodeI(`EXEC_OP_BEQ, 5'd2, 16'h0010), bpc, 32'd9, 32'd9);
		sendInstr(encodeI(`EXEC_OP_BEQ, 5'd2, 16'h0010), bpc, 32'd9, 32'd8);
		sendInstr(encodeI(`EXEC_OP_BNE, 5'd2, 16'hfff0), bpc, 32'd9, 32'd9);
		sendInstr(encodeI(`EXEC_OP_BNE, 5'd2, 16'hfff0), bpc, 32'd9, 32'd8);
		sendInstr(encodeI(`EXEC_OP_BGTZ, 5'd0, 16'h0004), bpc, 32'd1, 32'd0);
		sendInstr(encodeI(`EXEC_OP_BGTZ, 5'd0, 16'h0004), bpc, 32'd0, 32'd0);
		sendInstr(encodeI(`EXEC_OP_BLEZ, 5'd0, 16'hfffc), bpc, 32'd0, 32'd0);
		sendInstr(encodeI(`EXEC_OP_BLEZ, 5'd0, 16'hfffc), bpc, 32'd1, 32'd0);
		sendInstr(encodeI(`EXEC_OP_REGIMM, `EXEC_RT_BGEZ, 16'h0020), bpc, 32'd0, 32'd0);
		sendInstr(encodeI(`EXEC_OP_REGIMM, `EXEC_RT_BGEZ, 16'h0020), bpc, 32'hffff_ffff, 32'd0);
		sendInstr(encodeI(`EXEC_OP_REGIMM, `EXEC_RT_BLTZ, 16'h8000), bpc, 32'hffff_ffff, 32'd0);
		sendInstr(encodeI(`EXEC_OP_REGIMM, `EXEC_RT_BLTZ, 16'h8000), bpc, 32'd0, 32'd0);
	endtask

	task automatic sendReservedCodes();
		sendInstr(encodeI(6'h3f, 5'd4, 16'h1234), basePc, 32'd1, 32'd2);
		sendInstr(encodeR(6'h01, 5'd3, 5'd0), basePc, 32'd1, 32'd2);
		// unused REGIMM selector
		sendInstr(encodeI(`EXEC_OP_REGIMM, 5'h05, 16'h0004), basePc, 32'd1, 32'd2);
		// r0 targets never write
		sendInstr(encodeR(`EXEC_FN_ADD, 5'd0, 5'd0), basePc, 32'd1, 32'd2);
		sendInstr(encodeI(`EXEC_OP_ADDI, 5'd0, 16'h0001), basePc, 32'd1, 32'd2);
	endtask

	// back-to-back strobes with three in flight
	task automatic streamRandom();
		logic [31:0] rs;
		logic [31:0] rt;
		for (int i = 0; i < randomStrobes; i++) begin
			rs = pickOperand();
			rt = pickOperand();
			if ($urandom_range(0, 3) == 0)
				rt = rs;
			sendInstr(randomInstr(), $urandom & 32'hffff_fffc, rs, rt);
		end
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		void'($urandom(32'h0e2b_ab0b));
		clk = 1'b0;
		rstN = 1'b0;
		instValid = 1'b0;
		instr = '0;
		pc = '0;
		rsValue = '0;
		rtValue = '0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		failedTests = 0;
		repeat (5) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;

		errMark = errorCount;
		driveAluOps();
		finishTest("aluOps", aluStrobes, errMark);
		errMark = errorCount;
		checkOverflowLimits();
		finishTest("overflow", ovfStrobes, errMark);
		errMark = errorCount;
		walkBranches();
		finishTest("branches", branchStrobes, errMark);
		errMark = errorCount;
		sendReservedCodes();
		finishTest("reserved", reservedStrobes, errMark);
		errMark = errorCount;
		streamRandom();
		finishTest("randomStream", randomStrobes, errMark);

		$display("summary: %0d checks, %0d errors, %0d of 5 tests failed",
			checkCount, errorCount, failedTests);
		if (errorCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: mipsExec.f
+incdir+common
common/execPkg.sv
source/instrDecode.sv
alu/aluCore.sv
source/branchCompare.sv
source/resultMerge.sv
source/mipsExec.sv
dv/mipsExecTb.sv

// File: Bender.yml
package:
  name: mipsExec

sources:
  - include_dirs:
      - common
    files:
      - common/execPkg.sv
      - source/instrDecode.sv
      - alu/aluCore.sv
      - source/branchCompare.sv
      - source/resultMerge.sv
      - source/mipsExec.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/mipsExecTb.sv
